// File: tb.f
verilog/arena_geometry_pkg.sv
verilog/game_timing_pkg.sv
verilog/button_debouncer.sv
verilog/player_cannon.sv
verilog/invader_formation.sv
verilog/wave_controller.sv
verilog/invaders_core.sv
bench/invaders_tb.sv

// File: Bender.yml
package:
  name: invaders_core

sources:
  - verilog/arena_geometry_pkg.sv
  - verilog/game_timing_pkg.sv
  - verilog/button_debouncer.sv
  - verilog/player_cannon.sv
  - verilog/invader_formation.sv
  - verilog/wave_controller.sv
  - verilog/invaders_core.sv
  - target: test
    files:
      - bench/invaders_tb.sv

// File: bench/invaders_tb.sv
`timescale 1ns/100ps

module invaders_tb;
    import arena_geometry_pkg::*;
    import game_timing_pkg::*;

    localparam int BTN_RIGHT    = 0;
    localparam int BTN_LEFT     = 1;
    localparam int BTN_FIRE     = 2;
    localparam int PRESS_CYCLES = 28;
    localparam int REFIRE_GAP   = 14;

    logic   clk = 1'b0;
    logic   rst;
    logic   btn_right;
    logic   btn_left;
    logic   btn_fire;
    coord_t player_x;
    coord_t shot_x;
    coord_t shot_y;
    coord_t anchor_x;
    coord_t anchor_y;
    logic   shot_active;
    alive_t alive;
    logic   splash;

    // a hold of zero in the stimulus table means a random glitch
    int     step_btn [$];
    int     step_reps [$];
    int     step_hold [$];
    int     step_rel [$];
    coord_t step_exp [$];

    logic [31:0] rng_state = 32'h1186;
    coord_t      exp_px;
    alive_t      alive_model;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    invaders_core dut0 (
        .clk         (clk),
        .rst         (rst),
        .btn_right   (btn_right),
        .btn_left    (btn_left),
        .btn_fire    (btn_fire),
        .player_x    (player_x),
        .shot_x      (shot_x),
        .shot_y      (shot_y),
        .anchor_x    (anchor_x),
        .anchor_y    (anchor_y),
        .shot_active (shot_active),
        .alive       (alive),
        .splash      (splash)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int table_cycles();
        int total;
        total = 0;
        for (int i = 0; i < step_btn.size(); i++) begin
            total += step_reps[i] * ((step_hold[i] == 0 ? DEBOUNCE_CYCLES : step_hold[i])
                                     + step_rel[i]);
        end
        return total;
    endfunction

    // left column before the anchor, right column after it
    function automatic int column_start(input int col, input coord_t ax);
        case (col)
            0:       return int'(ax) - int'(COL_OFFSET_LEFT);
            1:       return int'(ax);
            default: return int'(ax) + int'(COL_OFFSET_RIGHT);
        endcase
    endfunction

    function automatic coord_t hit_line(input int row, input coord_t ay);
        case (row)
            0:       return ay + ROW_HIT_BOTTOM;
            1:       return ay - ROW_HIT_MIDDLE;
            default: return ay - ROW_HIT_TOP;
        endcase
    endfunction

    // a shot meets the lowest live invader of its column first
    function automatic int lowest_alive_row(input int col);
        for (int r = 0; r < FORM_ROWS; r++) begin
            if (alive_model[r*FORM_COLS + col]) begin
                return r;
            end
        end
        return -1;
    endfunction

    task automatic check_coord(input coord_t got, input coord_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "coordinate mismatch");
        end
    endtask

    task automatic check_alive(input alive_t got, input alive_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s, got %b, expected %b", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "alive mask mismatch");
        end
    endtask

    task automatic check_period(input period_t got, input period_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "period mismatch");
        end
    endtask

    // inputs change and outputs are read just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic set_button(input int which, input logic level);
        case (which)
            BTN_RIGHT: btn_right = level;
            BTN_LEFT:  btn_left = level;
            default:   btn_fire = level;
        endcase
    endtask

    task automatic press_button(input int which, input int hold, input int rel);
        set_button(which, 1'b1);
        repeat (hold) next_cycle();
        set_button(which, 1'b0);
        repeat (rel) next_cycle();
    endtask

    task automatic add_step(input int btn, input int reps, input int hold, input int rel,
                            input coord_t exp);
        step_btn.push_back(btn);
        step_reps.push_back(reps);
        step_hold.push_back(hold);
        step_rel.push_back(rel);
        step_exp.push_back(exp);
    endtask

    task automatic wait_anchor_step(output int cycles);
        coord_t prev;
        prev   = anchor_x;
        cycles = 0;
        do begin
            next_cycle();
            cycles++;
        end while (anchor_x == prev);
    endtask

    // keep one pixel of margin on each side for a march step in flight
    task automatic aim_column(input int col);
        int  lo;
        int  pos;
        bit  done;
        done = 1'b0;
        while (!done) begin
            lo  = column_start(col, anchor_x);
            pos = int'(exp_px) + int'(SHOT_X_OFFSET);
            if (pos < lo + 1) begin
                press_button(BTN_RIGHT, 14, 14);
                exp_px = exp_px + PLAYER_STEP;
                check_coord(player_x, exp_px, "player_x while aiming right");
            end else if (pos > lo + int'(INVADER_WIDTH) - 1) begin
                press_button(BTN_LEFT, 14, 14);
                exp_px = exp_px - PLAYER_STEP;
                check_coord(player_x, exp_px, "player_x while aiming left");
            end else begin
                done = 1'b1;
            end
        end
    endtask

    task automatic fire_shot(input bit refire, output coord_t last_y);
        coord_t launch_x;
        set_button(BTN_FIRE, 1'b1);
        while (!shot_active) next_cycle();
        check_coord(shot_x, exp_px + SHOT_X_OFFSET, "shot x at launch");
        check_coord(shot_y, SHOT_Y_START, "shot y at launch");
        set_button(BTN_FIRE, 1'b0);
        launch_x = shot_x;
        if (refire) begin
            // a second fire in flight must not restart the shot
            repeat (REFIRE_GAP) next_cycle();
            press_button(BTN_FIRE, REFIRE_GAP, REFIRE_GAP);
            check_coord(shot_x, launch_x, "shot x after fire in flight");
            check_coord(shot_y, SHOT_Y_START - 10'(3 * REFIRE_GAP), "shot y after fire in flight");
        end
        last_y = shot_y;
        while (shot_active) begin
            last_y = shot_y;
            next_cycle();
        end
    endtask

    initial begin
        int     hold;
        int     cycles;
        int     period_1;
        int     period_2;
        int     splash_len;
        int     col;
        int     row;
        coord_t last_y;

        rst       = 1'b1;
        btn_right = 1'b0;
        btn_left  = 1'b0;
        btn_fire  = 1'b0;
        alive_model = '1;

        add_step(BTN_RIGHT, 1, 14, 14, 10'd350);
        add_step(BTN_LEFT, 1, 14, 14, 10'd340);
        add_step(BTN_RIGHT, 6, 0, 14, 10'd340);
        add_step(BTN_LEFT, 6, 0, 14, 10'd340);
        // long holds still give one step each
        add_step(BTN_RIGHT, 3, 30, 14, 10'd370);
        add_step(BTN_RIGHT, 40, 14, 14, 10'd744);
        add_step(BTN_LEFT, 61, 14, 14, 10'd144);

        cycle_limit = table_cycles() + 4 * int'(SPLASH_CYCLES)
                      + 10 * (int'(SHOT_Y_START) + 20 * PRESS_CYCLES)
                      + 4 * int'(MARCH_PERIOD_INIT);

        repeat (2) next_cycle();
        rst = 1'b0;
        exp_px = PLAYER_X_RESET;

        // first step drops the formation and turns it right
        wait_anchor_step(cycles);
        check_coord(anchor_x, FORM_X_RESET + 10'd1, "anchor_x after first step");
        check_coord(anchor_y, FORM_Y_RESET + FORM_DROP, "anchor_y after first step");
        wait_anchor_step(period_1);
        check_period(period_t'(period_1), MARCH_PERIOD_INIT, "march interval in wave one");

        for (int i = 0; i < step_btn.size(); i++) begin
            for (int n = 0; n < step_reps[i]; n++) begin
                hold = step_hold[i];
                if (hold == 0) begin
                    rng_state = xorshift32(rng_state);
                    hold = 1 + int'(rng_state % (DEBOUNCE_CYCLES - 1));
                end
                press_button(step_btn[i], hold, step_rel[i]);
            end
            check_coord(player_x, step_exp[i], "player_x after table step");
            exp_px = step_exp[i];
        end

        // the cannon sits far left of the formation so this shot misses
        fire_shot(1'b1, last_y);
        check_coord(last_y, SHOT_Y_END, "shot y at expiry");
        check_alive(alive, alive_model, "alive after a miss");

        for (int k = 0; k < 9; k++) begin
            col = k % FORM_COLS;
            row = lowest_alive_row(col);
            aim_column(col);
            fire_shot(1'b0, last_y);
            check_coord(last_y, hit_line(row, anchor_y), "shot y at hit");
            alive_model[row*FORM_COLS + col] = 1'b0;
            check_alive(alive, alive_model, "alive after hit");
        end

        while (!splash) next_cycle();
        splash_len = 0;
        while (splash) begin
            check_alive(alive, '0, "alive during splash");
            next_cycle();
            splash_len++;
        end
        check_period(period_t'(splash_len), SPLASH_CYCLES, "splash length");
        // restart pulse takes effect at the next edge
        next_cycle();
        check_alive(alive, '1, "alive after restart");
        check_coord(player_x, PLAYER_X_RESET, "player_x after restart");
        check_coord(anchor_x, FORM_X_RESET, "anchor_x after restart");
        check_coord(anchor_y, FORM_Y_RESET, "anchor_y after restart");

        wait_anchor_step(cycles);
        check_coord(anchor_x, FORM_X_RESET + 10'd1, "anchor_x after first step of wave two");
        wait_anchor_step(period_2);
        check_period(period_t'(period_2), MARCH_PERIOD_INIT - MARCH_SPEEDUP,
                     "march interval in wave two");

        $display("TEST OK");
        $finish;
    end

endmodule

// File: verilog/invaders_core.sv
`timescale 1ns/100ps

module invaders_core (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        btn_right,
    input  logic                        btn_left,
    input  logic                        btn_fire,
    output arena_geometry_pkg::coord_t  player_x,
    output arena_geometry_pkg::coord_t  shot_x,
    output arena_geometry_pkg::coord_t  shot_y,
    output arena_geometry_pkg::coord_t  anchor_x,
    output arena_geometry_pkg::coord_t  anchor_y,
    output logic                        shot_active,
    output arena_geometry_pkg::alive_t  alive,
    output logic                        splash
);
    import game_timing_pkg::*;

    logic    right_press;
    logic    left_press;
    logic    fire_press;
    logic    shot_hit;
    logic    wave_restart;
    period_t march_period;

    // one filter per push button
    button_debouncer u_right_db (
        .clk    (clk),
        .rst    (rst),
        .button (btn_right),
        .press  (right_press)
    );

    button_debouncer u_left_db (
        .clk    (clk),
        .rst    (rst),
        .button (btn_left),
        .press  (left_press)
    );

    button_debouncer u_fire_db (
        .clk    (clk),
        .rst    (rst),
        .button (btn_fire),
        .press  (fire_press)
    );

    player_cannon u_cannon (
        .clk          (clk),
        .rst          (rst),
        .right_press  (right_press),
        .left_press   (left_press),
        .fire_press   (fire_press),
        .shot_hit     (shot_hit),
        .wave_restart (wave_restart),
        .splash       (splash),
        .player_x     (player_x),
        .shot_active  (shot_active),
        .shot_x       (shot_x),
        .shot_y       (shot_y)
    );

    invader_formation u_formation (
        .clk          (clk),
        .rst          (rst),
        .shot_active  (shot_active),
        .shot_x       (shot_x),
        .shot_y       (shot_y),
        .march_period (march_period),
        .splash       (splash),
        .wave_restart (wave_restart),
        .anchor_x     (anchor_x),
        .anchor_y     (anchor_y),
        .alive        (alive),
        .shot_hit     (shot_hit)
    );

    wave_controller u_waves (
        .clk          (clk),
        .rst          (rst),
        .alive        (alive),
        .splash       (splash),
        .wave_restart (wave_restart),
        .march_period (march_period)
    );

endmodule

// File: verilog/wave_controller.sv
`timescale 1ns/100ps

module wave_controller (
    input  logic                        clk,
    input  logic                        rst,
    input  arena_geometry_pkg::alive_t  alive,
    output logic                        splash,
    output logic                        wave_restart,
    output game_timing_pkg::period_t    march_period
);
    import game_timing_pkg::*;

    period_t splash_cnt;
    logic    wave_clear;

    // alive is still zero in the restart cycle itself
    assign wave_clear = (alive == '0) && !splash && !wave_restart;

    always_ff @(posedge clk) begin
        if (rst) begin
            splash       <= 1'b0;
            wave_restart <= 1'b0;
            splash_cnt   <= '0;
            march_period <= MARCH_PERIOD_INIT;
        end else begin
            wave_restart <= 1'b0;
            if (wave_clear) begin
                splash     <= 1'b1;
                splash_cnt <= '0;
            end else if (splash) begin
                if (splash_cnt >= SPLASH_CYCLES - 16'd1) begin
                    splash       <= 1'b0;
                    wave_restart <= 1'b1;
                    // faster march next wave down to the floor
                    if (march_period >= MARCH_PERIOD_MIN + MARCH_SPEEDUP) begin
                        march_period <= march_period - MARCH_SPEEDUP;
                    end else begin
                        march_period <= MARCH_PERIOD_MIN;
                    end
                end else begin
                    splash_cnt <= splash_cnt + 16'd1;
                end
            end
        end
    end

    a_splash_on_clear: assert property (
        @(posedge clk) disable iff (rst)
        $rose(splash) |-> $past(alive) == '0
    ) else $error("splash rose with invaders alive");

endmodule

// File: verilog/invader_formation.sv
`timescale 1ns/100ps

module invader_formation (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        shot_active,
    input  arena_geometry_pkg::coord_t  shot_x,
    input  arena_geometry_pkg::coord_t  shot_y,
    input  game_timing_pkg::period_t    march_period,
    input  logic                        splash,
    input  logic                        wave_restart,
    output arena_geometry_pkg::coord_t  anchor_x,
    output arena_geometry_pkg::coord_t  anchor_y,
    output arena_geometry_pkg::alive_t  alive,
    output logic                        shot_hit
);
    import arena_geometry_pkg::*;
    import game_timing_pkg::*;

    period_t march_cnt;
    logic    dir_right;
    logic    drop_pending;
    logic    step_dir;
    coord_t  step_x;
    coord_t  row_line [FORM_ROWS];
    coord_t  col_lo [FORM_COLS];
    alive_t  hit_vec;

    // a pending drop reverses before the sideways move
    assign step_dir = drop_pending ? !dir_right : dir_right;
    assign step_x   = step_dir ? anchor_x + 10'd1 : anchor_x - 10'd1;

    // one march step per period and no march during splash
    always_ff @(posedge clk) begin
        if (rst || wave_restart) begin
            march_cnt    <= '0;
            anchor_x     <= FORM_X_RESET;
            anchor_y     <= FORM_Y_RESET;
            dir_right    <= 1'b0;
            drop_pending <= 1'b1;
        end else if (!splash) begin
            if (march_cnt >= march_period - 16'd1) begin
                march_cnt <= '0;
                anchor_x  <= step_x;
                dir_right <= step_dir;
                if (drop_pending) begin
                    anchor_y <= anchor_y + FORM_DROP;
                end
                drop_pending <= (step_x >= FORM_X_MAX) || (step_x <= FORM_X_MIN);
            end else begin
                march_cnt <= march_cnt + 16'd1;
            end
        end
    end

    // hit lines per row
    assign row_line[0] = anchor_y + ROW_HIT_BOTTOM;
    assign row_line[1] = anchor_y - ROW_HIT_MIDDLE;
    assign row_line[2] = anchor_y - ROW_HIT_TOP;

    // column start points
    assign col_lo[0] = anchor_x - COL_OFFSET_LEFT;
    assign col_lo[1] = anchor_x;
    assign col_lo[2] = anchor_x + COL_OFFSET_RIGHT;

    // columns never overlap, so at most one bit is set
    always_comb begin
        hit_vec = '0;
        for (int r = 0; r < FORM_ROWS; r++) begin
            for (int c = 0; c < FORM_COLS; c++) begin
                if (shot_active && alive[r*FORM_COLS + c]
                    && shot_y == row_line[r]
                    && shot_x >= col_lo[c]
                    && shot_x <= col_lo[c] + INVADER_WIDTH) begin
                    hit_vec[r*FORM_COLS + c] = 1'b1;
                end
            end
        end
    end

    assign shot_hit = |hit_vec;

    // killed invader drops out at the next edge
    always_ff @(posedge clk) begin
        if (rst || wave_restart) begin
            alive <= '1;
        end else begin
            alive <= alive & ~hit_vec;
        end
    end

    // a hit needs a live shot, and the cannon retires it next cycle
    a_hit_ends_shot: assert property (
        @(posedge clk) disable iff (rst || wave_restart)
        shot_hit |-> shot_active ##1 !shot_active
    ) else $error("hit without a shot, or shot survived a hit");

endmodule

// File: verilog/player_cannon.sv
`timescale 1ns/100ps

module player_cannon (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        right_press,
    input  logic                        left_press,
    input  logic                        fire_press,
    input  logic                        shot_hit,
    input  logic                        wave_restart,
    input  logic                        splash,
    output arena_geometry_pkg::coord_t  player_x,
    output logic                        shot_active,
    output arena_geometry_pkg::coord_t  shot_x,
    output arena_geometry_pkg::coord_t  shot_y
);
    import arena_geometry_pkg::*;
    import game_timing_pkg::*;

    period_t shot_cnt;
    logic    move_right;
    logic    move_left;
    logic    launch;

    // right beats left beats fire and nothing moves during splash
    assign move_right = right_press && !splash;
    assign move_left  = left_press && !right_press && !splash;
    assign launch     = fire_press && !right_press && !left_press && !splash
                        && !shot_active;

    // cannon position saturates at both edges
    always_ff @(posedge clk) begin
        if (rst || wave_restart) begin
            player_x <= PLAYER_X_RESET;
        end else if (move_right) begin
            if (player_x >= PLAYER_X_MAX - PLAYER_STEP) begin
                player_x <= PLAYER_X_MAX;
            end else begin
                player_x <= player_x + PLAYER_STEP;
            end
        end else if (move_left) begin
            if (player_x <= PLAYER_X_MIN + PLAYER_STEP) begin
                player_x <= PLAYER_X_MIN;
            end else begin
                player_x <= player_x - PLAYER_STEP;
            end
        end
    end

    // single shot in flight
    always_ff @(posedge clk) begin
        if (rst || wave_restart) begin
            shot_active <= 1'b0;
            shot_cnt    <= '0;
        end else if (shot_active) begin
            if (shot_hit || shot_y <= SHOT_Y_END) begin
                shot_active <= 1'b0;
            end else if (shot_cnt >= SHOT_PERIOD - 16'd1) begin
                shot_cnt <= '0;
            end else begin
                shot_cnt <= shot_cnt + 16'd1;
            end
        end else if (launch) begin
            shot_active <= 1'b1;
            shot_cnt    <= '0;
        end
    end

    // shot position is only meaningful while active
    always_ff @(posedge clk) begin
        if (launch) begin
            shot_x <= player_x + SHOT_X_OFFSET;
            shot_y <= SHOT_Y_START;
        end else if (shot_active && !shot_hit && shot_y > SHOT_Y_END
                     && shot_cnt >= SHOT_PERIOD - 16'd1) begin
            shot_y <= shot_y - 10'd1;
        end
    end

    a_player_in_range: assert property (
        @(posedge clk) disable iff (rst)
        player_x >= PLAYER_X_MIN && player_x <= PLAYER_X_MAX
    ) else $error("player_x left its range");

    // flight never overshoots the ceiling
    a_shot_in_range: assert property (
        @(posedge clk) disable iff (rst)
        shot_active |-> (shot_y >= SHOT_Y_END && shot_y <= SHOT_Y_START)
    ) else $error("shot_y outside flight range");

endmodule

// File: verilog/button_debouncer.sv
`timescale 1ns/100ps

module button_debouncer (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic press
);
    import game_timing_pkg::*;

    logic                      sync_0;
    logic                      sync_1;
    logic                      pressed;
    logic [DEBOUNCE_CNT_W-1:0] stable_cnt;

    // two-flop synchronizer
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_0 <= 1'b0;
            sync_1 <= 1'b0;
        end else begin
            sync_0 <= button;
            sync_1 <= sync_0;
        end
    end

    // count samples that disagree with the settled state
    // a full run flips the state, rising flip gives one press
    always_ff @(posedge clk) begin
        if (rst) begin
            pressed    <= 1'b0;
            stable_cnt <= '0;
            press      <= 1'b0;
        end else begin
            press <= 1'b0;
            if (sync_1 == pressed) begin
                stable_cnt <= '0;
            end else if (stable_cnt == DEBOUNCE_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                stable_cnt <= '0;
                pressed    <= sync_1;
                press      <= sync_1;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // a held button never repeats
    a_press_single: assert property (
        @(posedge clk) disable iff (rst) press |=> !press
    ) else $error("press high on two consecutive cycles");

endmodule

// File: verilog/game_timing_pkg.sv
package game_timing_pkg;

    // tick period in clock cycles
    typedef logic [15:0] period_t;

    // button filter
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int DEBOUNCE_CNT_W  = $clog2(DEBOUNCE_CYCLES + 1);

    // shot moves one pixel per period
    localparam period_t SHOT_PERIOD = 16'd1;

    // march speed per wave
    localparam period_t MARCH_PERIOD_INIT = 16'd512;
    localparam period_t MARCH_SPEEDUP     = 16'd64;
    localparam period_t MARCH_PERIOD_MIN  = 16'd128;

    // pause between waves
    localparam period_t SPLASH_CYCLES = 16'd256;

endpackage

// File: verilog/arena_geometry_pkg.sv
package arena_geometry_pkg;

    // screen coordinate and per-invader live flags
    typedef logic [9:0] coord_t;

    // bottom row first, then left, middle and right within a row
    typedef logic [8:0] alive_t;

    // formation shape
    localparam int FORM_ROWS = 3;
    localparam int FORM_COLS = 3;

    // player cannon
    localparam coord_t PLAYER_X_RESET = 10'd340;
    localparam coord_t PLAYER_X_MIN   = 10'd144;
    localparam coord_t PLAYER_X_MAX   = 10'd744;
    localparam coord_t PLAYER_STEP    = 10'd10;

    // shot launch point and ceiling
    localparam coord_t SHOT_X_OFFSET = 10'd15;
    localparam coord_t SHOT_Y_START  = 10'd400;
    localparam coord_t SHOT_Y_END    = 10'd34;

    // formation anchor start and march limits
    localparam coord_t FORM_X_RESET = 10'd340;
    localparam coord_t FORM_Y_RESET = 10'd84;
    localparam coord_t FORM_X_MIN   = 10'd144;
    localparam coord_t FORM_X_MAX   = 10'd764;
    localparam coord_t FORM_DROP    = 10'd10;

    // one invader sprite
    localparam coord_t INVADER_WIDTH = 10'd20;

    // left column sits before the anchor, right column after it
    localparam coord_t COL_OFFSET_LEFT  = 10'd25;
    localparam coord_t COL_OFFSET_RIGHT = 10'd25;

    // hit line magnitudes from anchor y
    // bottom row is below the anchor, middle and top rows above it
    localparam coord_t ROW_HIT_BOTTOM = 10'd20;
    localparam coord_t ROW_HIT_MIDDLE = 10'd25;
    localparam coord_t ROW_HIT_TOP    = 10'd50;

endpackage
